// File: include/exec_macros.svh
/* execute cluster sizing
   datapath width, reorder buffer tag width and issue queue depth */

`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// operand and result width
`define EXEC_XLEN 32

// reorder buffer tag, 16 ops in flight at most
`define ROB_TAG_W 4

// issue queue entries, 2, 4 or 8
`define IQ_DEPTH 4

`endif

// File: rtl/exec_pkg.sv
/* exec_pkg
   op encoding for renamed micro-ops and the functional unit each op runs on */

package exec_pkg;

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_BEQ = 4'd2,
		OP_BNE = 4'd3,
		OP_BLT = 4'd4, // signed
		OP_AND = 4'd5,
		OP_OR  = 4'd6,
		OP_XOR = 4'd7,
		OP_SLL = 4'd8,
		OP_SRL = 4'd9  // logical
	} exec_op_t;

	typedef enum logic {
		UNIT_ADD   = 1'b0,
		UNIT_LOGIC = 1'b1
	} exec_unit_t;

	// compares go to the adder too
	function automatic exec_unit_t unit_of(input exec_op_t op);
		case (op)
			OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: unit_of = UNIT_LOGIC;
			default: unit_of = UNIT_ADD;
		endcase
	endfunction

endpackage

// File: rtl/issue_queue.sv
/* issue_queue
   age-ordered reservation queue, issues the oldest op whose unit is ready,
   one op per cycle, onto a shared set of issue fields */

`timescale 1ns/1ps
`include "exec_macros.svh"

module issue_queue import exec_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_valid,
	input  exec_op_t               dispatch_op,
	input  logic [`ROB_TAG_W-1:0]  dispatch_tag,
	input  logic [`EXEC_XLEN-1:0]  dispatch_rs1,
	input  logic [`EXEC_XLEN-1:0]  dispatch_rs2,
	output logic                   dispatch_ready,
	input  logic                   add_ready,
	input  logic                   logic_ready,
	output logic                   add_valid,
	output logic                   logic_valid,
	output exec_op_t               issue_op,
	output logic [`ROB_TAG_W-1:0]  issue_tag,
	output logic [`EXEC_XLEN-1:0]  issue_rs1,
	output logic [`EXEC_XLEN-1:0]  issue_rs2
);

	localparam int IDX_W = $clog2(`IQ_DEPTH);

	logic [`IQ_DEPTH-1:0] occupied;
	logic [IDX_W-1:0]     age [`IQ_DEPTH]; // count of younger entries
	exec_op_t             op_q [`IQ_DEPTH];
	logic [`ROB_TAG_W-1:0] tag_q [`IQ_DEPTH];
	logic [`EXEC_XLEN-1:0] rs1_q [`IQ_DEPTH];
	logic [`EXEC_XLEN-1:0] rs2_q [`IQ_DEPTH];

	logic [`IQ_DEPTH-1:0] eligible;
	logic                 issue_found;
	logic [IDX_W-1:0]     issue_idx;
	exec_unit_t           issue_unit;
	logic                 issue_fire;
	logic                 wr_en;
	logic [IDX_W-1:0]     wr_idx;

	always_comb begin
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			eligible[i] = occupied[i] &&
				((unit_of(op_q[i]) == UNIT_ADD) ? add_ready : logic_ready);
		end
	end

	// oldest eligible entry has the largest age
	always_comb begin
		issue_found = 1'b0;
		issue_idx = '0;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			if (eligible[i] && (!issue_found || age[i] > age[issue_idx])) begin
				issue_found = 1'b1;
				issue_idx = IDX_W'(i);
			end
		end
	end

	// lowest free slot
	always_comb begin
		wr_idx = '0;
		for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
			if (!occupied[i])
				wr_idx = IDX_W'(i);
		end
	end

	assign issue_unit = unit_of(op_q[issue_idx]);
	assign add_valid = issue_found && (issue_unit == UNIT_ADD);
	assign logic_valid = issue_found && (issue_unit == UNIT_LOGIC);
	assign issue_op = op_q[issue_idx];
	assign issue_tag = tag_q[issue_idx];
	assign issue_rs1 = rs1_q[issue_idx];
	assign issue_rs2 = rs2_q[issue_idx];

	assign issue_fire = (add_valid && add_ready) || (logic_valid && logic_ready);
	assign dispatch_ready = ~&occupied;
	assign wr_en = dispatch_valid && dispatch_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			occupied <= '0;
			for (int i = 0; i < `IQ_DEPTH; i++)
				age[i] <= '0;
		end else begin
			for (int i = 0; i < `IQ_DEPTH; i++) begin
				if (issue_fire && IDX_W'(i) == issue_idx) begin
					occupied[i] <= 1'b0;
				end else if (occupied[i]) begin
					// one fewer younger entry when a younger one issues, one more on a write
					age[i] <= age[i] - IDX_W'(issue_fire && age[i] > age[issue_idx])
						+ IDX_W'(wr_en);
				end
			end
			if (wr_en) begin
				occupied[wr_idx] <= 1'b1;
				age[wr_idx] <= '0; // youngest
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			op_q[wr_idx] <= dispatch_op;
			tag_q[wr_idx] <= dispatch_tag;
			rs1_q[wr_idx] <= dispatch_rs1;
			rs2_q[wr_idx] <= dispatch_rs2;
		end
	end

	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !occupied[wr_idx]);

	a_one_issue: assert property (@(posedge clk) disable iff (rst)
		!(add_valid && logic_valid));

endmodule

// File: rtl/add_sub_unit.sv
/* add_sub_unit
   ripple-carry add/subtract with zero, negative and overflow flags,
   resolves BEQ/BNE/BLT and holds the result until the CDB takes it */

`timescale 1ns/1ps
`include "exec_macros.svh"

module add_sub_unit import exec_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   valid_in,
	input  logic                   yumi,
	input  exec_op_t               op,
	input  logic [`ROB_TAG_W-1:0]  tag,
	input  logic [`EXEC_XLEN-1:0]  rs1,
	input  logic [`EXEC_XLEN-1:0]  rs2,
	output logic                   ready,
	output logic                   valid_out,
	output logic                   branch_taken,
	output logic [`ROB_TAG_W-1:0]  result_tag,
	output logic [`EXEC_XLEN-1:0]  result
);

	logic                 sub;
	logic [`EXEC_XLEN-1:0] b_in;
	logic [`EXEC_XLEN-1:0] sum;
	logic [`EXEC_XLEN:0]   carry;
	logic                 zero;
	logic                 negative;
	logic                 overflow;
	logic                 taken;
	logic                 accept;

	assign sub = (op != OP_ADD); // compares subtract too
	assign b_in = sub ? ~rs2 : rs2;
	assign carry[0] = sub; // +1 for two's complement

	genvar i;
	generate
		for (i = 0; i < `EXEC_XLEN; i++) begin : g_ripple
			assign sum[i] = rs1[i] ^ b_in[i] ^ carry[i];
			assign carry[i+1] = (rs1[i] & b_in[i]) | (carry[i] & (rs1[i] ^ b_in[i]));
		end
	endgenerate

	assign zero = (sum == '0);
	assign negative = sum[`EXEC_XLEN-1];
	assign overflow = carry[`EXEC_XLEN] ^ carry[`EXEC_XLEN-1];

	always_comb begin
		case (op)
			OP_BEQ: taken = zero;
			OP_BNE: taken = !zero;
			OP_BLT: taken = negative ^ overflow; // signed less than
			default: taken = 1'b0;
		endcase
	end

	assign ready = !valid_out;
	assign accept = valid_in && ready;

	always_ff @(posedge clk) begin
		if (rst)
			valid_out <= 1'b0;
		else if (yumi)
			valid_out <= 1'b0;
		else if (accept)
			valid_out <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result <= sum;
			result_tag <= tag;
			branch_taken <= taken;
		end
	end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		valid_out && !yumi |=> $stable(result) && $stable(result_tag)
			&& $stable(branch_taken));

endmodule

// File: rtl/logic_unit.sv
/* logic_unit
   AND/OR/XOR and logical shifts, result held until the CDB takes it */

`timescale 1ns/1ps
`include "exec_macros.svh"

module logic_unit import exec_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   valid_in,
	input  logic                   yumi,
	input  exec_op_t               op,
	input  logic [`ROB_TAG_W-1:0]  tag,
	input  logic [`EXEC_XLEN-1:0]  rs1,
	input  logic [`EXEC_XLEN-1:0]  rs2,
	output logic                   ready,
	output logic                   valid_out,
	output logic [`ROB_TAG_W-1:0]  result_tag,
	output logic [`EXEC_XLEN-1:0]  result
);

	localparam int SH_W = $clog2(`EXEC_XLEN);

	logic [SH_W-1:0]       shamt;
	logic [`EXEC_XLEN-1:0] res_d;
	logic                 accept;

	assign shamt = rs2[SH_W-1:0]; // low bits only

	always_comb begin
		case (op)
			OP_AND: res_d = rs1 & rs2;
			OP_OR:  res_d = rs1 | rs2;
			OP_XOR: res_d = rs1 ^ rs2;
			OP_SLL: res_d = rs1 << shamt;
			OP_SRL: res_d = rs1 >> shamt; // zero fill
			default: res_d = '0;
		endcase
	end

	assign ready = !valid_out;
	assign accept = valid_in && ready;

	always_ff @(posedge clk) begin
		if (rst)
			valid_out <= 1'b0;
		else if (yumi)
			valid_out <= 1'b0;
		else if (accept)
			valid_out <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result <= res_d;
			result_tag <= tag;
		end
	end

	// queue must see ready low while we hold
	a_no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
		valid_out |-> !valid_in);

endmodule

// File: rtl/cdb_arbiter.sv
/* cdb_arbiter
   round-robin choice between the two units for the common data bus,
   grant is locked while the bus is stalled, yumi goes back to the winner */

`timescale 1ns/1ps
`include "exec_macros.svh"

module cdb_arbiter import exec_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   add_valid_out,
	input  logic                   add_branch_taken,
	input  logic                   logic_valid_out,
	input  logic [`ROB_TAG_W-1:0]  add_tag,
	input  logic [`EXEC_XLEN-1:0]  add_result,
	input  logic [`ROB_TAG_W-1:0]  logic_tag,
	input  logic [`EXEC_XLEN-1:0]  logic_result,
	output logic                   add_yumi,
	output logic                   logic_yumi,
	input  logic                   cdb_ready,
	output logic                   cdb_valid,
	output logic                   cdb_branch_taken,
	output logic [`ROB_TAG_W-1:0]  cdb_tag,
	output logic [`EXEC_XLEN-1:0]  cdb_result
);

	exec_unit_t last_grant;
	exec_unit_t held_unit;
	logic       held; // bus stalled last cycle
	exec_unit_t grant;
	logic       xfer;

	always_comb begin
		if (held)
			grant = held_unit;
		else if (add_valid_out && logic_valid_out)
			grant = (last_grant == UNIT_ADD) ? UNIT_LOGIC : UNIT_ADD;
		else if (add_valid_out)
			grant = UNIT_ADD;
		else
			grant = UNIT_LOGIC;
	end

	assign cdb_valid = add_valid_out || logic_valid_out;
	assign xfer = cdb_valid && cdb_ready;
	assign add_yumi = xfer && (grant == UNIT_ADD);
	assign logic_yumi = xfer && (grant == UNIT_LOGIC);

	assign cdb_tag = (grant == UNIT_ADD) ? add_tag : logic_tag;
	assign cdb_result = (grant == UNIT_ADD) ? add_result : logic_result;
	assign cdb_branch_taken = (grant == UNIT_ADD) && add_branch_taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_grant <= UNIT_LOGIC; // add goes first
			held <= 1'b0;
			held_unit <= UNIT_ADD;
		end else begin
			if (xfer)
				last_grant <= grant;
			held <= cdb_valid && !cdb_ready;
			held_unit <= grant;
		end
	end

	a_one_yumi: assert property (@(posedge clk) disable iff (rst)
		!(add_yumi && logic_yumi));

	// stalled broadcast stays put, relies on the units holding too
	a_stall_stable: assert property (@(posedge clk) disable iff (rst)
		cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_tag) && $stable(cdb_result));

endmodule

// File: rtl/exec_cluster.sv
/* exec_cluster
   integer execute cluster, issue queue feeding an add/sub unit and a
   logic unit that share one common data bus */

`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_cluster import exec_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_valid,
	input  exec_op_t               dispatch_op,
	input  logic [`ROB_TAG_W-1:0]  dispatch_tag,
	input  logic [`EXEC_XLEN-1:0]  dispatch_rs1,
	input  logic [`EXEC_XLEN-1:0]  dispatch_rs2,
	output logic                   dispatch_ready,
	input  logic                   cdb_ready,
	output logic                   cdb_valid,
	output logic                   cdb_branch_taken,
	output logic [`ROB_TAG_W-1:0]  cdb_tag,
	output logic [`EXEC_XLEN-1:0]  cdb_result
);

	// issue side, fields shared by both units
	logic                  add_valid, add_ready;
	logic                  logic_valid, logic_ready;
	exec_op_t              issue_op;
	logic [`ROB_TAG_W-1:0] issue_tag;
	logic [`EXEC_XLEN-1:0] issue_rs1, issue_rs2;

	// completion side
	logic                  add_valid_out, add_branch_taken, add_yumi;
	logic [`ROB_TAG_W-1:0] add_tag;
	logic [`EXEC_XLEN-1:0] add_result;
	logic                  logic_valid_out, logic_yumi;
	logic [`ROB_TAG_W-1:0] logic_tag;
	logic [`EXEC_XLEN-1:0] logic_result;

	issue_queue u_iq (
		.clk, .rst,
		.dispatch_valid, .dispatch_op, .dispatch_tag, .dispatch_rs1, .dispatch_rs2,
		.dispatch_ready,
		.add_ready, .logic_ready, .add_valid, .logic_valid,
		.issue_op, .issue_tag, .issue_rs1, .issue_rs2
	);

	add_sub_unit u_add (
		.clk, .rst, .valid_in(add_valid), .yumi(add_yumi),
		.op(issue_op), .tag(issue_tag), .rs1(issue_rs1), .rs2(issue_rs2),
		.ready(add_ready), .valid_out(add_valid_out), .branch_taken(add_branch_taken),
		.result_tag(add_tag), .result(add_result)
	);

	logic_unit u_logic (
		.clk, .rst, .valid_in(logic_valid), .yumi(logic_yumi),
		.op(issue_op), .tag(issue_tag), .rs1(issue_rs1), .rs2(issue_rs2),
		.ready(logic_ready), .valid_out(logic_valid_out),
		.result_tag(logic_tag), .result(logic_result)
	);

	cdb_arbiter u_arb (
		.clk, .rst,
		.add_valid_out, .add_branch_taken, .logic_valid_out,
		.add_tag, .add_result, .logic_tag, .logic_result,
		.add_yumi, .logic_yumi,
		.cdb_ready, .cdb_valid, .cdb_branch_taken, .cdb_tag, .cdb_result
	);

endmodule

// File: tests/tb_exec_cluster.sv
/* tb_exec_cluster
   file-driven testbench for the execute cluster, random CDB back-pressure,
   a stalled burst that fills the issue queue, per-tag scoreboard */

`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_exec_cluster import exec_pkg::*; ();

	localparam int MAX_TESTS = 64;
	localparam int N_TAGS = 2 ** `ROB_TAG_W;
	localparam int BURST_LEN = 8; // trailing add-unit ops

	logic                  clk;
	logic                  rst;
	logic                  dispatch_valid;
	exec_op_t              dispatch_op;
	logic [`ROB_TAG_W-1:0] dispatch_tag;
	logic [`EXEC_XLEN-1:0] dispatch_rs1;
	logic [`EXEC_XLEN-1:0] dispatch_rs2;
	logic                  dispatch_ready;
	logic                  cdb_ready = 1'b0;
	logic                  cdb_valid;
	logic                  cdb_branch_taken;
	logic [`ROB_TAG_W-1:0] cdb_tag;
	logic [`EXEC_XLEN-1:0] cdb_result;

	// vectors from the data file
	int                    n_tests = 0;
	logic                  loaded = 1'b0;
	logic [`ROB_TAG_W-1:0] t_tag [MAX_TESTS];
	exec_op_t              t_op [MAX_TESTS];
	logic [`EXEC_XLEN-1:0] t_rs1 [MAX_TESTS];
	logic [`EXEC_XLEN-1:0] t_rs2 [MAX_TESTS];
	logic [`EXEC_XLEN-1:0] t_exp [MAX_TESTS];
	logic                  t_taken [MAX_TESTS];

	// scoreboard by tag
	logic                  pending [N_TAGS];
	logic [`EXEC_XLEN-1:0] exp_result [N_TAGS];
	logic                  exp_taken [N_TAGS];

	int     err_setup = 0;
	int     err_check = 0;
	int     err_stall = 0;
	int     timeouts = 0;
	int     cycles = 0;
	int     accepted = 0;
	int     retired = 0;
	integer seed = 32'hc508e8fc;
	logic   burst_on = 1'b0;
	logic   burst_done = 1'b0;
	logic   saw_full = 1'b0;
	int     stall_cycles = 0;
	int     full_cycles = 0;

	exec_cluster DUT (
		.clk, .rst,
		.dispatch_valid, .dispatch_op, .dispatch_tag, .dispatch_rs1, .dispatch_rs2,
		.dispatch_ready,
		.cdb_ready, .cdb_valid, .cdb_branch_taken, .cdb_tag, .cdb_result
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// {known, op} for an op name in the file
	function automatic logic [4:0] op_code(input string name);
		case (name)
			"ADD": op_code = {1'b1, OP_ADD};
			"SUB": op_code = {1'b1, OP_SUB};
			"BEQ": op_code = {1'b1, OP_BEQ};
			"BNE": op_code = {1'b1, OP_BNE};
			"BLT": op_code = {1'b1, OP_BLT};
			"AND": op_code = {1'b1, OP_AND};
			"OR":  op_code = {1'b1, OP_OR};
			"XOR": op_code = {1'b1, OP_XOR};
			"SLL": op_code = {1'b1, OP_SLL};
			"SRL": op_code = {1'b1, OP_SRL};
			default: op_code = 5'd0;
		endcase
	endfunction

	task automatic load_tests();
		int          fd;
		int          got;
		int          fields;
		string       line;
		string       name;
		logic [31:0] tag_v, rs1_v, rs2_v, exp_v, tk_v;
		logic [4:0]  code;
		fd = $fopen("tests/exec_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/exec_tests.txt");
			err_setup++;
		end else begin
			while (!$feof(fd) && n_tests < MAX_TESTS) begin
				line = "";
				got = $fgets(line, fd);
				if (got != 0 && line.len() > 0 && line[0] != "#") begin
					fields = $sscanf(line, "%h %s %h %h %h %h",
						tag_v, name, rs1_v, rs2_v, exp_v, tk_v);
					code = op_code(name);
					if (fields == 6 && code[4]) begin
						t_tag[n_tests] = tag_v[`ROB_TAG_W-1:0];
						t_op[n_tests] = exec_op_t'(code[3:0]);
						t_rs1[n_tests] = rs1_v;
						t_rs2[n_tests] = rs2_v;
						t_exp[n_tests] = exp_v;
						t_taken[n_tests] = tk_v[0];
						n_tests++;
					end else if (fields > 0) begin
						$display("bad line in test file: %s", line);
						err_setup++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_idle(input string when);
		if (cdb_valid !== 1'b0 || dispatch_ready !== 1'b1) begin
			$display("FAIL %0t %s: cdb_valid %b dispatch_ready %b, expected 0 and 1",
				$time, when, cdb_valid, dispatch_ready);
			err_setup++;
		end
	endtask

	// starts and ends on a falling edge
	task automatic send_op(input int k);
		while (pending[t_tag[k]])
			@(negedge clk); // tag still in flight
		dispatch_valid = 1'b1;
		dispatch_op = t_op[k];
		dispatch_tag = t_tag[k];
		dispatch_rs1 = t_rs1[k];
		dispatch_rs2 = t_rs2[k];
		@(posedge clk);
		while (!dispatch_ready)
			@(posedge clk);
		@(negedge clk);
		dispatch_valid = 1'b0;
	endtask

	task automatic finish_run();
		int total;
		total = err_setup + err_check + err_stall;
		$display("errors %0d, timeouts %0d", total, timeouts);
		if (total == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// scoreboard and dispatch bookkeeping
	always @(posedge clk) begin
		cycles++;
		if (rst) begin
			for (int t = 0; t < N_TAGS; t++)
				pending[t] = 1'b0;
		end else begin
			if (cdb_valid && cdb_ready) begin
				if (!pending[cdb_tag]) begin
					$display("%0t: CDB broadcast for tag %0d, which has no op in flight",
						$time, cdb_tag);
					err_check++;
				end else begin
					if (cdb_result !== exp_result[cdb_tag] ||
						cdb_branch_taken !== exp_taken[cdb_tag]) begin
						$display("FAIL %0t tag %0d: expected result %h taken %b, got %h taken %b",
							$time, cdb_tag, exp_result[cdb_tag], exp_taken[cdb_tag],
							cdb_result, cdb_branch_taken);
						err_check++;
					end
					pending[cdb_tag] = 1'b0;
					retired++;
				end
			end
			if (dispatch_valid && dispatch_ready) begin
				pending[dispatch_tag] = 1'b1;
				exp_result[dispatch_tag] = t_exp[accepted];
				exp_taken[dispatch_tag] = t_taken[accepted];
				accepted++;
				if (accepted == n_tests - BURST_LEN)
					burst_on = 1'b1;
			end
		end
	end

	// cdb_ready, random or held low for the burst
	always @(negedge clk) begin
		if (burst_on && !burst_done) begin
			stall_cycles++;
			if (!dispatch_ready) begin
				saw_full = 1'b1;
				full_cycles++;
			end
			if (full_cycles >= 3 || stall_cycles >= 40) begin
				burst_done = 1'b1;
				if (!saw_full) begin
					$display("dispatch_ready never fell while the CDB was stalled");
					err_stall++;
				end
			end
		end
		if (rst || (burst_on && !burst_done))
			cdb_ready = 1'b0;
		else
			cdb_ready = ({$random(seed)} % 100) < 60; // about 60 percent
	end

	initial begin
		int limit;
		wait (loaded);
		limit = 40 * n_tests + 100;
		wait (cycles >= limit);
		$display("timeout after %0d cycles, tags still pending:", cycles);
		for (int t = 0; t < N_TAGS; t++) begin
			if (pending[t])
				$display("  tag %0d", t);
		end
		timeouts = 1;
		finish_run();
	end

	initial begin
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_op = OP_ADD;
		dispatch_tag = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		load_tests();
		loaded = 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_idle("during reset");
		end
		rst = 1'b0;
		@(negedge clk);
		check_idle("after reset");
		for (int k = 0; k < n_tests; k++)
			send_op(k);
		while (retired < n_tests)
			@(negedge clk);
		finish_run();
	end

endmodule

// File: vlog.f
+incdir+include
rtl/exec_pkg.sv
rtl/issue_queue.sv
rtl/add_sub_unit.sv
rtl/logic_unit.sv
rtl/cdb_arbiter.sv
rtl/exec_cluster.sv
tests/tb_exec_cluster.sv

// File: Makefile
# Verilator build and run of the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
SEED      ?= 1
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -Mdir $(BUILD) -f vlog.f
	@out=$$(./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD)

// File: tests/exec_tests.txt
# columns, all hex: tag op rs1 rs2 expected_result expected_taken
# the last eight lines are add-unit ops, dispatched while the CDB is stalled
0 ADD 00000005 00000003 00000008 0
1 ADD ffffffff 00000001 00000000 0
2 SUB 00000003 00000005 fffffffe 0
3 SUB 80000000 00000001 7fffffff 0
4 BEQ 12345678 12345678 00000000 1
5 BNE 12345678 12345679 ffffffff 1
6 BLT 80000000 00000001 7fffffff 1
7 BLT 00000001 80000000 80000001 0
8 AND f0f0f0f0 ff00ff00 f000f000 0
9 OR f0f0f0f0 0f0f0000 fffff0f0 0
a XOR aaaaaaaa ffff0000 5555aaaa 0
b SLL 00000001 00000024 00000010 0
c SRL 80000000 0000001f 00000001 0
d BEQ 00000007 00000008 ffffffff 0
e BNE 00000009 00000009 00000000 0
f ADD 7fffffff 00000001 80000000 0
0 SUB 00000000 00000001 ffffffff 0
1 BLT fffffffe ffffffff ffffffff 1
2 BLT 00000005 00000005 00000000 0
3 ADD 12345678 87654321 99999999 0
4 SUB 00000010 00000010 00000000 0
